// File: design/cpuControlPkg.sv
// CPU control package with instruction byte views, phase encodings and datapath select codes
`default_nettype none

package cpuControlPkg;

	// Bit positions in the 4-bit status word
	localparam int unsigned FlagZ = 0;
	localparam int unsigned FlagC = 1;
	localparam int unsigned FlagV = 2;
	localparam int unsigned FlagN = 3;

	// Operation code, top five bits of the instruction byte
	typedef enum logic [4:0] {
		ADD       = 5'd0,
		ADDI      = 5'd1,
		ADDIB     = 5'd2,
		ADC       = 5'd3,
		ADCI      = 5'd4,
		SUB       = 5'd5,
		SUBI      = 5'd6,
		SUBIB     = 5'd7,
		SUC       = 5'd8,
		SUCI      = 5'd9,
		NEG       = 5'd10,
		CMP       = 5'd11,
		CMPI      = 5'd12,
		AND       = 5'd13,
		OR        = 5'd14,
		XOR       = 5'd15,
		NAND      = 5'd16,
		NOR       = 5'd17,
		NOT       = 5'd18,
		LSL       = 5'd19,
		LSR       = 5'd20,
		ASR       = 5'd21,
		LUI       = 5'd22,
		LLI       = 5'd23,
		LDW       = 5'd24,
		STW       = 5'd25,
		BRANCH    = 5'd26,
		INTERRUPT = 5'd27
	} opcode_t;

	// Branch condition in the low three bits
	typedef enum logic [2:0] {BR, BNE, BE, BLT, BGE, BWL, RET, JMP} branch_t;

	// INTERRUPT sub-code, stack-based codes are not supported
	typedef enum logic [2:0] {
		IntEnableOp  = 3'd1,
		IntDisableOp = 3'd2
	} intOp_t;

	typedef struct packed {
		opcode_t opcode;
		branch_t cond;
	} branchView_t;

	typedef struct packed {
		opcode_t opcode;
		intOp_t  subOp;
	} intView_t;

	// Low field means a branch code or an interrupt sub-code, by opcode
	typedef union packed {
		branchView_t brView;
		intView_t    intView;
	} instrWord_t;

	typedef enum logic [1:0] {Fetch, Execute, Interrupt} majorState_t;
	typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycle_t;

	// Datapath selects
	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Sel_t;
	typedef enum logic {ImmShort, ImmLong} immSel_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1Sel_t;
	typedef enum logic {RwRd, RwSp} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;
	// Forced OR into the ALU result for stack pointer stepping
	typedef enum logic [1:0] {NoOr, SubOr, AddOr} aluOr_t;

endpackage

`default_nettype wire

// File: design/statusUnit.sv
// Status unit holding the flag register, interrupt request sync and branch condition check
`default_nettype none
`timescale 1ns/10ps

module statusUnit #(
	parameter int IrqSyncStages = 2
) (
	input wire Clock,
	input wire nReset,
	input wire nIRQ,
	input wire StatusWe,
	input wire IntEnable,
	input wire IntDisable,
	input wire [3:0] Flags,
	input wire cpuControlPkg::instrWord_t Instr,
	output logic [3:0] StatusReg,
	output logic BranchTaken,
	output logic IntReq
);

	logic [IrqSyncStages-1:0] irqSync;
	logic intEnabled;

	// Flags from the ALU
	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			StatusReg <= 4'b0000;
		end else if (StatusWe) begin
			StatusReg <= Flags;
		end
	end

	// Request chain, stage 0 takes the raw pin
	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqSync <= '0;
		end else begin
			irqSync[0] <= ~nIRQ;
			for (int i = 1; i < IrqSyncStages; i++) begin
				irqSync[i] <= irqSync[i-1];
			end
		end
	end

	// Disable has priority
	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			intEnabled <= 1'b0;
		end else if (IntDisable) begin
			intEnabled <= 1'b0;
		end else if (IntEnable) begin
			intEnabled <= 1'b1;
		end
	end

	assign IntReq = irqSync[IrqSyncStages-1] & intEnabled;

	// Conditions against the stored flags
	always_comb begin
		case (Instr.brView.cond)
			cpuControlPkg::BR,
			cpuControlPkg::BWL: BranchTaken = 1'b1;
			cpuControlPkg::BNE: BranchTaken = ~StatusReg[cpuControlPkg::FlagZ];
			cpuControlPkg::BE:  BranchTaken = StatusReg[cpuControlPkg::FlagZ];
			cpuControlPkg::BLT: BranchTaken = StatusReg[cpuControlPkg::FlagN] ^
				StatusReg[cpuControlPkg::FlagV];
			cpuControlPkg::BGE: BranchTaken = ~(StatusReg[cpuControlPkg::FlagN] ^
				StatusReg[cpuControlPkg::FlagV]);
			// RET and JMP are unconditional and steered elsewhere
			default: BranchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/phaseSequencer.sv
// Phase sequencer stepping fetch, execute and interrupt entry through their sub-cycles
`default_nettype none
`timescale 1ns/10ps

module phaseSequencer (
	input wire Clock,
	input wire nReset,
	input wire nWait,
	input wire IntReq,
	input wire cpuControlPkg::instrWord_t Instr,
	output cpuControlPkg::majorState_t Phase,
	output cpuControlPkg::subCycle_t SubCycle
);

	cpuControlPkg::majorState_t nextPhase;
	cpuControlPkg::subCycle_t nextSub;
	cpuControlPkg::majorState_t endPhase;
	cpuControlPkg::subCycle_t endSub;

	// Where an instruction goes when it finishes
	assign endPhase = IntReq ? cpuControlPkg::Interrupt : cpuControlPkg::Fetch;
	assign endSub = IntReq ? cpuControlPkg::Cycle4 : cpuControlPkg::Cycle0;

	always_comb begin
		nextPhase = Phase;
		nextSub = SubCycle;
		case (SubCycle)
			cpuControlPkg::Cycle0: nextSub = cpuControlPkg::Cycle1;
			cpuControlPkg::Cycle1: nextSub = cpuControlPkg::Cycle2;
			cpuControlPkg::Cycle2: begin
				// Interrupt entry never waits
				if (nWait || Phase == cpuControlPkg::Interrupt) begin
					nextSub = cpuControlPkg::Cycle3;
				end
			end
			cpuControlPkg::Cycle3: begin
				if (Phase == cpuControlPkg::Fetch) begin
					nextPhase = cpuControlPkg::Execute;
					nextSub = cpuControlPkg::Cycle4;
				end else if (Phase == cpuControlPkg::Execute) begin
					nextPhase = endPhase;
					nextSub = endSub;
				end else begin
					nextPhase = cpuControlPkg::Fetch;
					nextSub = cpuControlPkg::Cycle0;
				end
			end
			cpuControlPkg::Cycle4: begin
				if (Phase == cpuControlPkg::Execute) begin
					case (Instr.brView.opcode)
						cpuControlPkg::LDW,
						cpuControlPkg::STW: nextSub = cpuControlPkg::Cycle0;
						cpuControlPkg::INTERRUPT: begin
							nextPhase = cpuControlPkg::Fetch;
							nextSub = cpuControlPkg::Cycle0;
						end
						// Single-cycle ALU and branch operations
						default: begin
							nextPhase = endPhase;
							nextSub = endSub;
						end
					endcase
				end else begin
					nextSub = cpuControlPkg::Cycle0;
				end
			end
			default: begin
				nextPhase = cpuControlPkg::Fetch;
				nextSub = cpuControlPkg::Cycle0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			Phase <= cpuControlPkg::Fetch;
			SubCycle <= cpuControlPkg::Cycle0;
		end else begin
			Phase <= nextPhase;
			SubCycle <= nextSub;
		end
	end

endmodule

`default_nettype wire

// File: design/controlDecoder.sv
// Control decoder turning phase, sub-cycle and instruction into datapath and memory controls
`default_nettype none
`timescale 1ns/10ps

module controlDecoder (
	input wire cpuControlPkg::instrWord_t Instr,
	input wire cpuControlPkg::majorState_t Phase,
	input wire cpuControlPkg::subCycle_t SubCycle,
	input wire nWait,
	input wire BranchTaken,
	output logic Ale,
	output logic AluEn,
	output logic AluWe,
	output logic Enb,
	output logic IrWe,
	output logic LrEn,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output logic PcEn,
	output logic PcWe,
	output logic RegWe,
	output cpuControlPkg::aluOr_t AluOr,
	output cpuControlPkg::immSel_t ImmSel,
	output cpuControlPkg::lrSel_t LrSel,
	output cpuControlPkg::op1Sel_t Op1Sel,
	output cpuControlPkg::op2Sel_t Op2Sel,
	output cpuControlPkg::pcSel_t PcSel,
	output cpuControlPkg::rs1Sel_t Rs1Sel,
	output cpuControlPkg::rwSel_t RwSel,
	output cpuControlPkg::wdSel_t WdSel,
	output logic StatusWe,
	output logic IntEnable,
	output logic IntDisable
);

	cpuControlPkg::opcode_t opcode;
	cpuControlPkg::branch_t branch;
	cpuControlPkg::intOp_t intOp;
	logic isLoad;

	assign opcode = Instr.brView.opcode;
	assign branch = Instr.brView.cond;
	assign intOp = Instr.intView.subOp;
	assign isLoad = (opcode == cpuControlPkg::LDW);

	always_comb begin
		Ale = 1'b0;
		AluEn = 1'b0;
		AluWe = 1'b0;
		Enb = 1'b0;
		IrWe = 1'b0;
		LrEn = 1'b0;
		LrWe = 1'b0;
		MemEn = 1'b0;
		nME = 1'b1;
		nOE = 1'b0;
		nWE = 1'b0;
		PcEn = 1'b0;
		PcWe = 1'b0;
		RegWe = 1'b0;
		AluOr = cpuControlPkg::NoOr;
		ImmSel = cpuControlPkg::ImmLong;
		LrSel = cpuControlPkg::LrSys;
		Op1Sel = cpuControlPkg::Op1Rd1;
		Op2Sel = cpuControlPkg::Op2Imm;
		PcSel = cpuControlPkg::Pc1;
		Rs1Sel = cpuControlPkg::Rs1Ra;
		RwSel = cpuControlPkg::RwRd;
		WdSel = cpuControlPkg::WdAlu;
		StatusWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;

		// Strobes shared by the memory cycles of every phase
		case (SubCycle)
			cpuControlPkg::Cycle0: begin
				Ale = (Phase == cpuControlPkg::Fetch) || (Phase == cpuControlPkg::Interrupt);
				nWE = 1'b1;
				nOE = 1'b1;
			end
			cpuControlPkg::Cycle1: begin
				nME = 1'b0;
				nWE = 1'b1;
				nOE = 1'b1;
			end
			cpuControlPkg::Cycle2: nME = 1'b0;
			default: ;
		endcase

		if (Phase == cpuControlPkg::Fetch) begin
			case (SubCycle)
				cpuControlPkg::Cycle0: PcEn = 1'b1;
				cpuControlPkg::Cycle1: begin
					MemEn = 1'b1;
					PcEn = 1'b1;
				end
				cpuControlPkg::Cycle2: begin
					MemEn = 1'b1;
					Enb = 1'b1;
					nWE = 1'b1;
					// Opcode byte is latched on the clock that ends the wait
					IrWe = nWait;
				end
				cpuControlPkg::Cycle3: begin
					nWE = 1'b1;
					PcEn = 1'b1;
				end
				default: ;
			endcase
		end else if (Phase == cpuControlPkg::Interrupt) begin
			// Push the return PC below the stack pointer, then jump to the vector
			case (SubCycle)
				cpuControlPkg::Cycle4: begin
					IntDisable = 1'b1;
					Rs1Sel = cpuControlPkg::Rs1Sp;
					RwSel = cpuControlPkg::RwSp;
					AluOr = cpuControlPkg::SubOr;
					Op2Sel = cpuControlPkg::Op2Zero;
					RegWe = 1'b1;
					AluWe = 1'b1;
					AluEn = 1'b1;
				end
				cpuControlPkg::Cycle0: begin
					Rs1Sel = cpuControlPkg::Rs1Sp;
					AluOr = cpuControlPkg::SubOr;
					Op2Sel = cpuControlPkg::Op2Zero;
					AluEn = 1'b1;
				end
				cpuControlPkg::Cycle1: begin
					Op2Sel = cpuControlPkg::Op2Zero;
					AluEn = 1'b1;
				end
				cpuControlPkg::Cycle2: begin
					PcEn = 1'b1;
					nOE = 1'b1;
				end
				cpuControlPkg::Cycle3: begin
					PcEn = 1'b1;
					nOE = 1'b1;
					PcWe = 1'b1;
					PcSel = cpuControlPkg::PcInt;
				end
				default: ;
			endcase
		end else if (Phase == cpuControlPkg::Execute && SubCycle == cpuControlPkg::Cycle4) begin
			case (opcode)
				cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB,
				cpuControlPkg::ADC, cpuControlPkg::ADCI, cpuControlPkg::SUB,
				cpuControlPkg::SUBI, cpuControlPkg::SUBIB, cpuControlPkg::SUC,
				cpuControlPkg::SUCI, cpuControlPkg::NEG, cpuControlPkg::CMP,
				cpuControlPkg::CMPI, cpuControlPkg::AND, cpuControlPkg::OR,
				cpuControlPkg::XOR, cpuControlPkg::NAND, cpuControlPkg::NOR,
				cpuControlPkg::NOT, cpuControlPkg::LSL, cpuControlPkg::LSR,
				cpuControlPkg::ASR: begin
					PcEn = 1'b1;
					PcWe = 1'b1;
					StatusWe = 1'b1;
					// Compares only update flags
					RegWe = (opcode != cpuControlPkg::CMP) && (opcode != cpuControlPkg::CMPI);
					case (opcode)
						cpuControlPkg::ADD, cpuControlPkg::SUB, cpuControlPkg::CMP,
						cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
						cpuControlPkg::NAND, cpuControlPkg::NOR: Op2Sel = cpuControlPkg::Op2Rd2;
						cpuControlPkg::ADDI, cpuControlPkg::SUBI, cpuControlPkg::CMPI,
						cpuControlPkg::LSL, cpuControlPkg::LSR,
						cpuControlPkg::ASR: ImmSel = cpuControlPkg::ImmShort;
						cpuControlPkg::ADDIB, cpuControlPkg::SUBIB: Rs1Sel = cpuControlPkg::Rs1Rd;
						default: ;
					endcase
				end
				cpuControlPkg::LUI, cpuControlPkg::LLI: begin
					Rs1Sel = cpuControlPkg::Rs1Rd;
					RegWe = 1'b1;
					PcWe = 1'b1;
					AluEn = 1'b1;
				end
				cpuControlPkg::LDW, cpuControlPkg::STW: begin
					// Effective address into the ALU register before the bus cycle
					ImmSel = cpuControlPkg::ImmShort;
					AluEn = 1'b1;
					AluWe = 1'b1;
				end
				cpuControlPkg::BRANCH: begin
					PcWe = 1'b1;
					case (branch)
						cpuControlPkg::RET: begin
							LrEn = 1'b1;
							PcSel = cpuControlPkg::PcSysbus;
						end
						cpuControlPkg::JMP: begin
							ImmSel = cpuControlPkg::ImmShort;
							PcSel = cpuControlPkg::PcAluOut;
						end
						default: begin
							Op1Sel = cpuControlPkg::Op1Pc;
							AluEn = 1'b1;
							if (BranchTaken) begin
								PcSel = cpuControlPkg::PcAluOut;
								// Link register keeps the return address
								if (branch == cpuControlPkg::BWL) begin
									LrWe = 1'b1;
									LrSel = cpuControlPkg::LrPc;
								end
							end
						end
					endcase
				end
				cpuControlPkg::INTERRUPT: begin
					if (intOp == cpuControlPkg::IntEnableOp || intOp == cpuControlPkg::IntDisableOp) begin
						PcWe = 1'b1;
						PcEn = 1'b1;
						IntEnable = (intOp == cpuControlPkg::IntEnableOp);
						IntDisable = (intOp == cpuControlPkg::IntDisableOp);
					end
				end
				default: ;
			endcase
		end else if (Phase == cpuControlPkg::Execute) begin
			// Data cycles of LDW and STW
			case (SubCycle)
				cpuControlPkg::Cycle0: begin
					ImmSel = cpuControlPkg::ImmShort;
					AluEn = 1'b1;
					Ale = 1'b1;
				end
				cpuControlPkg::Cycle1: begin
					Op2Sel = cpuControlPkg::Op2Zero;
					Rs1Sel = cpuControlPkg::Rs1Rd;
					MemEn = isLoad;
					AluWe = 1'b1;
					AluEn = 1'b1;
				end
				cpuControlPkg::Cycle2: begin
					PcWe = nWait;
					if (isLoad) begin
						MemEn = 1'b1;
						Enb = 1'b1;
						nWE = 1'b1;
						WdSel = cpuControlPkg::WdSys;
						RegWe = 1'b1;
					end else begin
						AluEn = 1'b1;
						nOE = 1'b1;
						Op2Sel = cpuControlPkg::Op2Zero;
					end
				end
				cpuControlPkg::Cycle3: begin
					if (isLoad) begin
						nWE = 1'b1;
						PcEn = 1'b1;
					end else begin
						nOE = 1'b1;
						AluEn = 1'b1;
						Op2Sel = cpuControlPkg::Op2Zero;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/cpuControl.sv
// Top level of the CPU control unit joining status, sequencing and decode
`default_nettype none
`timescale 1ns/10ps

module cpuControl #(
	parameter int IrqSyncStages = 2
) (
	input wire Clock,
	input wire nReset,
	input wire nWait,
	input wire nIRQ,
	input wire [3:0] Flags,
	input wire cpuControlPkg::instrWord_t Instr,
	output logic Ale,
	output logic AluEn,
	output logic AluWe,
	output logic CFlag,
	output logic Enb,
	output logic IrWe,
	output logic LrEn,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output logic PcEn,
	output logic PcWe,
	output logic RegWe,
	output cpuControlPkg::aluOr_t AluOr,
	output cpuControlPkg::immSel_t ImmSel,
	output cpuControlPkg::lrSel_t LrSel,
	output cpuControlPkg::op1Sel_t Op1Sel,
	output cpuControlPkg::op2Sel_t Op2Sel,
	output cpuControlPkg::pcSel_t PcSel,
	output cpuControlPkg::rs1Sel_t Rs1Sel,
	output cpuControlPkg::rwSel_t RwSel,
	output cpuControlPkg::wdSel_t WdSel,
	output logic [3:0] StatusReg
);

	logic statusWe;
	logic intEnable;
	logic intDisable;
	logic intReq;
	logic branchTaken;
	cpuControlPkg::majorState_t phase;
	cpuControlPkg::subCycle_t subCycle;

	assign CFlag = StatusReg[cpuControlPkg::FlagC];

	statusUnit #(.IrqSyncStages(IrqSyncStages)) u_statusUnit (
		.Clock(Clock), .nReset(nReset), .nIRQ(nIRQ),
		.StatusWe(statusWe), .IntEnable(intEnable), .IntDisable(intDisable),
		.Flags(Flags), .Instr(Instr),
		.StatusReg(StatusReg), .BranchTaken(branchTaken), .IntReq(intReq)
	);

	phaseSequencer u_phaseSequencer (
		.Clock(Clock), .nReset(nReset), .nWait(nWait), .IntReq(intReq),
		.Instr(Instr), .Phase(phase), .SubCycle(subCycle)
	);

	controlDecoder u_controlDecoder (
		.Instr(Instr), .Phase(phase), .SubCycle(subCycle),
		.nWait(nWait), .BranchTaken(branchTaken),
		.Ale(Ale), .AluEn(AluEn), .AluWe(AluWe), .Enb(Enb), .IrWe(IrWe),
		.LrEn(LrEn), .LrWe(LrWe), .MemEn(MemEn), .nME(nME), .nOE(nOE),
		.nWE(nWE), .PcEn(PcEn), .PcWe(PcWe), .RegWe(RegWe),
		.AluOr(AluOr), .ImmSel(ImmSel), .LrSel(LrSel), .Op1Sel(Op1Sel),
		.Op2Sel(Op2Sel), .PcSel(PcSel), .Rs1Sel(Rs1Sel), .RwSel(RwSel),
		.WdSel(WdSel),
		.StatusWe(statusWe), .IntEnable(intEnable), .IntDisable(intDisable)
	);

endmodule

`default_nettype wire

// File: test/cpuControlModel.svh
// Reference model of the control unit phases, status word, interrupt enable and control outputs
`ifndef CPU_CONTROL_MODEL_SVH
`define CPU_CONTROL_MODEL_SVH

typedef struct packed {
	logic ale, aluEn, aluWe, enb, irWe, lrEn, lrWe;
	logic memEn, nME, nOE, nWE, pcEn, pcWe, regWe;
	logic statusWe, intEnable, intDisable;
	cpuControlPkg::aluOr_t aluOr;
	cpuControlPkg::immSel_t immSel;
	cpuControlPkg::lrSel_t lrSel;
	cpuControlPkg::op1Sel_t op1Sel;
	cpuControlPkg::op2Sel_t op2Sel;
	cpuControlPkg::pcSel_t pcSel;
	cpuControlPkg::rs1Sel_t rs1Sel;
	cpuControlPkg::rwSel_t rwSel;
	cpuControlPkg::wdSel_t wdSel;
} controls_t;

cpuControlPkg::majorState_t modelPhase = cpuControlPkg::Fetch;
cpuControlPkg::subCycle_t modelSub = cpuControlPkg::Cycle0;
logic [3:0] modelStatus = 4'b0000;
logic modelIntEn = 1'b0;
logic [SyncStages-1:0] modelSync = '0;

function automatic logic branchTakenOf(input cpuControlPkg::branch_t cond, input logic [3:0] st);
	logic lessThan;
	lessThan = st[cpuControlPkg::FlagN] != st[cpuControlPkg::FlagV];
	case (cond)
		cpuControlPkg::BR, cpuControlPkg::BWL: return 1'b1;
		cpuControlPkg::BNE: return !st[cpuControlPkg::FlagZ];
		cpuControlPkg::BE: return st[cpuControlPkg::FlagZ];
		cpuControlPkg::BLT: return lessThan;
		cpuControlPkg::BGE: return !lessThan;
		default: return 1'b0;
	endcase
endfunction

// Execute Cycle4, the single-cycle work and the address step of LDW and STW
function automatic controls_t executeControls(input controls_t base,
		input cpuControlPkg::instrWord_t instr, input logic [3:0] st);
	controls_t c;
	cpuControlPkg::opcode_t op;
	cpuControlPkg::branch_t cond;
	c = base;
	op = instr.brView.opcode;
	cond = instr.brView.cond;
	if (op <= cpuControlPkg::ASR) begin
		c.pcEn = 1'b1;
		c.pcWe = 1'b1;
		c.statusWe = 1'b1;
		c.regWe = !(op inside {cpuControlPkg::CMP, cpuControlPkg::CMPI});
		if (op inside {cpuControlPkg::ADD, cpuControlPkg::SUB, cpuControlPkg::CMP,
				cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
				cpuControlPkg::NAND, cpuControlPkg::NOR})
			c.op2Sel = cpuControlPkg::Op2Rd2;
		if (op inside {cpuControlPkg::ADDI, cpuControlPkg::SUBI, cpuControlPkg::CMPI,
				cpuControlPkg::LSL, cpuControlPkg::LSR, cpuControlPkg::ASR})
			c.immSel = cpuControlPkg::ImmShort;
		if (op inside {cpuControlPkg::ADDIB, cpuControlPkg::SUBIB})
			c.rs1Sel = cpuControlPkg::Rs1Rd;
	end else if (op inside {cpuControlPkg::LUI, cpuControlPkg::LLI}) begin
		c.rs1Sel = cpuControlPkg::Rs1Rd;
		c.regWe = 1'b1;
		c.pcWe = 1'b1;
		c.aluEn = 1'b1;
	end else if (op inside {cpuControlPkg::LDW, cpuControlPkg::STW}) begin
		c.immSel = cpuControlPkg::ImmShort;
		c.aluEn = 1'b1;
		c.aluWe = 1'b1;
	end else if (op == cpuControlPkg::BRANCH) begin
		c.pcWe = 1'b1;
		if (cond == cpuControlPkg::RET) begin
			c.lrEn = 1'b1;
			c.pcSel = cpuControlPkg::PcSysbus;
		end else if (cond == cpuControlPkg::JMP) begin
			c.immSel = cpuControlPkg::ImmShort;
			c.pcSel = cpuControlPkg::PcAluOut;
		end else begin
			// PC-relative target
			c.op1Sel = cpuControlPkg::Op1Pc;
			c.aluEn = 1'b1;
			if (branchTakenOf(cond, st))
				c.pcSel = cpuControlPkg::PcAluOut;
			if (cond == cpuControlPkg::BWL) begin
				c.lrWe = 1'b1;
				c.lrSel = cpuControlPkg::LrPc;
			end
		end
	end else begin
		c.pcWe = 1'b1;
		c.pcEn = 1'b1;
		c.intEnable = instr.intView.subOp == cpuControlPkg::IntEnableOp;
		c.intDisable = instr.intView.subOp == cpuControlPkg::IntDisableOp;
	end
	return c;
endfunction

// Bus cycles of LDW and STW
function automatic controls_t memoryControls(input controls_t base,
		input cpuControlPkg::subCycle_t sub, input logic load, input logic waitDone);
	controls_t c;
	c = base;
	if (sub == cpuControlPkg::Cycle0) begin
		c.immSel = cpuControlPkg::ImmShort;
		c.aluEn = 1'b1;
		c.ale = 1'b1;
	end else if (sub == cpuControlPkg::Cycle1) begin
		c.op2Sel = cpuControlPkg::Op2Zero;
		c.rs1Sel = cpuControlPkg::Rs1Rd;
		c.memEn = load;
		c.aluWe = 1'b1;
		c.aluEn = 1'b1;
	end else if (load) begin
		c.nWE = 1'b1;
		if (sub == cpuControlPkg::Cycle2) begin
			c.memEn = 1'b1;
			c.enb = 1'b1;
			c.wdSel = cpuControlPkg::WdSys;
			c.regWe = 1'b1;
		end else begin
			c.pcEn = 1'b1;
		end
	end else begin
		// Store data driven, write strobe low
		c.aluEn = 1'b1;
		c.nOE = 1'b1;
		c.op2Sel = cpuControlPkg::Op2Zero;
	end
	if (sub == cpuControlPkg::Cycle2)
		c.pcWe = waitDone;
	return c;
endfunction

function automatic controls_t expectedControls(input cpuControlPkg::majorState_t phase,
		input cpuControlPkg::subCycle_t sub, input cpuControlPkg::instrWord_t instr,
		input logic waitDone, input logic [3:0] st);
	controls_t c;
	c = '0;
	c.immSel = cpuControlPkg::ImmLong;
	// Memory strobes follow the sub-cycle in every phase
	c.nME = !(sub inside {cpuControlPkg::Cycle1, cpuControlPkg::Cycle2});
	c.nOE = sub inside {cpuControlPkg::Cycle0, cpuControlPkg::Cycle1};
	c.nWE = c.nOE;
	c.ale = (sub == cpuControlPkg::Cycle0) && (phase != cpuControlPkg::Execute);
	if (phase == cpuControlPkg::Fetch) begin
		c.pcEn = sub != cpuControlPkg::Cycle2;
		c.memEn = sub inside {cpuControlPkg::Cycle1, cpuControlPkg::Cycle2};
		if (sub inside {cpuControlPkg::Cycle2, cpuControlPkg::Cycle3})
			c.nWE = 1'b1;
		if (sub == cpuControlPkg::Cycle2) begin
			c.enb = 1'b1;
			c.irWe = waitDone;
		end
	end else if (phase == cpuControlPkg::Interrupt) begin
		if (sub inside {cpuControlPkg::Cycle4, cpuControlPkg::Cycle0, cpuControlPkg::Cycle1}) begin
			c.op2Sel = cpuControlPkg::Op2Zero;
			c.aluEn = 1'b1;
		end else begin
			c.pcEn = 1'b1;
			c.nOE = 1'b1;
		end
		if (sub inside {cpuControlPkg::Cycle4, cpuControlPkg::Cycle0}) begin
			c.rs1Sel = cpuControlPkg::Rs1Sp;
			c.aluOr = cpuControlPkg::SubOr;
		end
		if (sub == cpuControlPkg::Cycle4) begin
			c.intDisable = 1'b1;
			c.rwSel = cpuControlPkg::RwSp;
			c.regWe = 1'b1;
			c.aluWe = 1'b1;
		end
		if (sub == cpuControlPkg::Cycle3) begin
			c.pcWe = 1'b1;
			c.pcSel = cpuControlPkg::PcInt;
		end
	end else if (sub == cpuControlPkg::Cycle4) begin
		c = executeControls(c, instr, st);
	end else begin
		c = memoryControls(c, sub, instr.brView.opcode == cpuControlPkg::LDW, waitDone);
	end
	return c;
endfunction

task automatic resetModel();
	modelPhase <= cpuControlPkg::Fetch;
	modelSub <= cpuControlPkg::Cycle0;
	modelStatus <= 4'b0000;
	modelIntEn <= 1'b0;
	modelSync <= '0;
endtask

task automatic advanceModel(input controls_t c, input logic waitDone, input logic irqLevel,
		input logic [3:0] flagsNow, input cpuControlPkg::instrWord_t instr);
	cpuControlPkg::majorState_t ph;
	cpuControlPkg::subCycle_t sb;
	cpuControlPkg::majorState_t donePhase;
	cpuControlPkg::subCycle_t doneSub;
	logic [SyncStages-1:0] syncNext;
	logic memOp;
	ph = modelPhase;
	sb = modelSub;
	memOp = instr.brView.opcode inside {cpuControlPkg::LDW, cpuControlPkg::STW};
	// End of an instruction goes to interrupt entry on a pending request
	donePhase = (modelSync[SyncStages-1] && modelIntEn) ?
		cpuControlPkg::Interrupt : cpuControlPkg::Fetch;
	doneSub = (donePhase == cpuControlPkg::Interrupt) ?
		cpuControlPkg::Cycle4 : cpuControlPkg::Cycle0;
	if (modelSub == cpuControlPkg::Cycle0) begin
		sb = cpuControlPkg::Cycle1;
	end else if (modelSub == cpuControlPkg::Cycle1) begin
		sb = cpuControlPkg::Cycle2;
	end else if (modelSub == cpuControlPkg::Cycle2) begin
		if (waitDone || modelPhase == cpuControlPkg::Interrupt)
			sb = cpuControlPkg::Cycle3;
	end else if (modelSub == cpuControlPkg::Cycle3) begin
		ph = (modelPhase == cpuControlPkg::Fetch) ? cpuControlPkg::Execute :
			(modelPhase == cpuControlPkg::Execute) ? donePhase : cpuControlPkg::Fetch;
		sb = (modelPhase == cpuControlPkg::Fetch) ? cpuControlPkg::Cycle4 :
			(modelPhase == cpuControlPkg::Execute) ? doneSub : cpuControlPkg::Cycle0;
	end else if (modelPhase == cpuControlPkg::Interrupt || memOp) begin
		sb = cpuControlPkg::Cycle0;
	end else if (instr.brView.opcode == cpuControlPkg::INTERRUPT) begin
		ph = cpuControlPkg::Fetch;
		sb = cpuControlPkg::Cycle0;
	end else begin
		ph = donePhase;
		sb = doneSub;
	end
	syncNext[0] = !irqLevel;
	for (int i = 1; i < SyncStages; i++)
		syncNext[i] = modelSync[i-1];
	modelPhase <= ph;
	modelSub <= sb;
	modelSync <= syncNext;
	if (c.statusWe)
		modelStatus <= flagsNow;
	if (c.intDisable)
		modelIntEn <= 1'b0;
	else if (c.intEnable)
		modelIntEn <= 1'b1;
endtask

`endif

// File: test/cpuControlTb.sv
// Testbench for the CPU control unit with random instructions checked against a reference model
`default_nettype none
`timescale 1ns/10ps

module cpuControlTb;

	localparam int SyncStages = 2;
	localparam int ClockPeriod = 20;
	localparam int ResetCycles = 16;
	localparam int NumInstr = 3000;
	localparam int WorstClocks = 9;

	logic Clock;
	logic nReset;
	logic nWait;
	logic nIRQ;
	logic [3:0] Flags;
	cpuControlPkg::instrWord_t Instr;
	logic Ale, AluEn, AluWe, CFlag, Enb, IrWe, LrEn, LrWe;
	logic MemEn, nME, nOE, nWE, PcEn, PcWe, RegWe;
	cpuControlPkg::aluOr_t AluOr;
	cpuControlPkg::immSel_t ImmSel;
	cpuControlPkg::lrSel_t LrSel;
	cpuControlPkg::op1Sel_t Op1Sel;
	cpuControlPkg::op2Sel_t Op2Sel;
	cpuControlPkg::pcSel_t PcSel;
	cpuControlPkg::rs1Sel_t Rs1Sel;
	cpuControlPkg::rwSel_t RwSel;
	cpuControlPkg::wdSel_t WdSel;
	logic [3:0] StatusReg;

	logic [15:0] lfsrState = 16'd10474;
	int instrCount = 0;
	logic armed = 1'b0;

	`include "cpuControlModel.svh"

	cpuControl #(.IrqSyncStages(SyncStages)) u_cpuControl (
		.Clock(Clock), .nReset(nReset), .nWait(nWait), .nIRQ(nIRQ),
		.Flags(Flags), .Instr(Instr),
		.Ale(Ale), .AluEn(AluEn), .AluWe(AluWe), .CFlag(CFlag), .Enb(Enb),
		.IrWe(IrWe), .LrEn(LrEn), .LrWe(LrWe), .MemEn(MemEn), .nME(nME),
		.nOE(nOE), .nWE(nWE), .PcEn(PcEn), .PcWe(PcWe), .RegWe(RegWe),
		.AluOr(AluOr), .ImmSel(ImmSel), .LrSel(LrSel), .Op1Sel(Op1Sel),
		.Op2Sel(Op2Sel), .PcSel(PcSel), .Rs1Sel(Rs1Sel), .RwSel(RwSel),
		.WdSel(WdSel), .StatusReg(StatusReg)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return bits;
	endfunction

	// Only the supported opcodes and INTERRUPT sub-codes
	function automatic cpuControlPkg::instrWord_t randomInstr();
		cpuControlPkg::instrWord_t w;
		logic [2:0] kind;
		kind = 3'(randomBits(3));
		w.brView.cond = cpuControlPkg::branch_t'(3'(randomBits(3)));
		case (kind)
			3'd0, 3'd1, 3'd2: w.brView.opcode = cpuControlPkg::opcode_t'(5'(randomBits(5) % 24));
			3'd3: w.brView.opcode = randomBits(1) ? cpuControlPkg::LDW : cpuControlPkg::STW;
			3'd4, 3'd5: w.brView.opcode = cpuControlPkg::BRANCH;
			default: begin
				w.intView.opcode = cpuControlPkg::INTERRUPT;
				w.intView.subOp = (kind == 3'd6) ? cpuControlPkg::IntEnableOp :
					cpuControlPkg::IntDisableOp;
			end
		endcase
		return w;
	endfunction

	task automatic abortRun();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped on first failure");
	endtask

	task automatic reportMismatch(input string name, input string expText, input string actText);
		$display("[ERROR] %0t %s expected %s actual %s", $time, name, expText, actText);
		abortRun();
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			reportMismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
	endtask

	task automatic checkStatus(input string name, input logic [3:0] expected, input logic [3:0] actual);
		if (actual !== expected)
			reportMismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
	endtask

	task automatic checkAluOr(input cpuControlPkg::aluOr_t expected, input cpuControlPkg::aluOr_t actual);
		if (actual !== expected)
			reportMismatch("AluOr", expected.name(), actual.name());
	endtask

	task automatic checkImmSel(input cpuControlPkg::immSel_t expected, input cpuControlPkg::immSel_t actual);
		if (actual !== expected)
			reportMismatch("ImmSel", expected.name(), actual.name());
	endtask

	task automatic checkLrSel(input cpuControlPkg::lrSel_t expected, input cpuControlPkg::lrSel_t actual);
		if (actual !== expected)
			reportMismatch("LrSel", expected.name(), actual.name());
	endtask

	task automatic checkOp1Sel(input cpuControlPkg::op1Sel_t expected, input cpuControlPkg::op1Sel_t actual);
		if (actual !== expected)
			reportMismatch("Op1Sel", expected.name(), actual.name());
	endtask

	task automatic checkOp2Sel(input cpuControlPkg::op2Sel_t expected, input cpuControlPkg::op2Sel_t actual);
		if (actual !== expected)
			reportMismatch("Op2Sel", expected.name(), actual.name());
	endtask

	task automatic checkPcSel(input cpuControlPkg::pcSel_t expected, input cpuControlPkg::pcSel_t actual);
		if (actual !== expected)
			reportMismatch("PcSel", expected.name(), actual.name());
	endtask

	task automatic checkRs1Sel(input cpuControlPkg::rs1Sel_t expected, input cpuControlPkg::rs1Sel_t actual);
		if (actual !== expected)
			reportMismatch("Rs1Sel", expected.name(), actual.name());
	endtask

	task automatic checkRwSel(input cpuControlPkg::rwSel_t expected, input cpuControlPkg::rwSel_t actual);
		if (actual !== expected)
			reportMismatch("RwSel", expected.name(), actual.name());
	endtask

	task automatic checkWdSel(input cpuControlPkg::wdSel_t expected, input cpuControlPkg::wdSel_t actual);
		if (actual !== expected)
			reportMismatch("WdSel", expected.name(), actual.name());
	endtask

	task automatic compareOutputs(input controls_t e);
		checkBit("Ale", e.ale, Ale);
		checkBit("AluEn", e.aluEn, AluEn);
		checkBit("AluWe", e.aluWe, AluWe);
		checkBit("Enb", e.enb, Enb);
		checkBit("IrWe", e.irWe, IrWe);
		checkBit("LrEn", e.lrEn, LrEn);
		checkBit("LrWe", e.lrWe, LrWe);
		checkBit("MemEn", e.memEn, MemEn);
		checkBit("nME", e.nME, nME);
		checkBit("nOE", e.nOE, nOE);
		checkBit("nWE", e.nWE, nWE);
		checkBit("PcEn", e.pcEn, PcEn);
		checkBit("PcWe", e.pcWe, PcWe);
		checkBit("RegWe", e.regWe, RegWe);
		checkBit("CFlag", modelStatus[cpuControlPkg::FlagC], CFlag);
		checkStatus("StatusReg", modelStatus, StatusReg);
		checkAluOr(e.aluOr, AluOr);
		checkImmSel(e.immSel, ImmSel);
		checkLrSel(e.lrSel, LrSel);
		checkOp1Sel(e.op1Sel, Op1Sel);
		checkOp2Sel(e.op2Sel, Op2Sel);
		checkPcSel(e.pcSel, PcSel);
		checkRs1Sel(e.rs1Sel, Rs1Sel);
		checkRwSel(e.rwSel, RwSel);
		checkWdSel(e.wdSel, WdSel);
	endtask

	// Compare against the model, then step it with the values of this edge
	always @(posedge Clock) begin
		controls_t expected;
		expected = expectedControls(modelPhase, modelSub, Instr, nWait, modelStatus);
		if (armed)
			compareOutputs(expected);
		armed <= 1'b1;
		if (!nReset)
			resetModel();
		else
			advanceModel(expected, nWait, nIRQ, Flags, Instr);
	end

	initial begin
		Clock = 1'b0;
		nReset = 1'b0;
		nWait = 1'b1;
		nIRQ = 1'b1;
		Flags = 4'b0000;
		Instr = '0;
		repeat (ResetCycles) @(posedge Clock);
		nReset <= 1'b1;
		while (instrCount < NumInstr) begin
			@(posedge Clock);
			// New instruction byte once the fetch latches it
			if (modelPhase == cpuControlPkg::Fetch && modelSub == cpuControlPkg::Cycle2 && nWait) begin
				Instr <= randomInstr();
				instrCount++;
			end
			nWait <= randomBits(2) != 0;
			Flags <= 4'(randomBits(4));
			if (randomBits(3) == 0)
				nIRQ <= !nIRQ;
		end
		@(posedge Clock);
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#((ResetCycles + NumInstr * WorstClocks) * ClockPeriod);
		$display("Timeout: %0d instructions did not complete in the allowed time", NumInstr);
		abortRun();
	end

endmodule

`default_nettype wire

// File: cpuControl.f
+incdir+test
design/cpuControlPkg.sv
design/statusUnit.sv
design/phaseSequencer.sv
design/controlDecoder.sv
design/cpuControl.sv
test/cpuControlTb.sv

// File: Makefile
TOP = cpuControlTb
SIM = obj_dir/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log; grep -q "^SIMULATION PASSED$$" sim.log

$(SIM): cpuControl.f design/*.sv test/cpuControlTb.sv test/cpuControlModel.svh
	verilator --binary --timing --timescale 1ns/10ps -f cpuControl.f \
		--top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/10ps -f cpuControl.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
